//--- rtl/fetch_pkg.sv
// ############################
// Sizes and types of the uncacheable fetch path
// One fixed line width and word width are supported
// LINE_W must hold a power-of-two number of fetch words
// ############################

`default_nettype none

package fetch_pkg;

  localparam int NUM_PORTS = 2;
  localparam int ADDR_W = 32;
  localparam int FETCH_DW = 32;
  localparam int LINE_W = 128;
  localparam int LINE_ALIGN = 4;
  localparam int FETCH_ALIGN = 2;
  localparam int WORD_SEL_W = LINE_ALIGN - FETCH_ALIGN;
  localparam int PENDING_DEPTH = 4;
  localparam int PENDING_PTR_W = $clog2(PENDING_DEPTH);
  localparam int PENDING_CNT_W = PENDING_PTR_W + 1;
  localparam int PORT_IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [FETCH_DW-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [NUM_PORTS-1:0] port_mask_t;
  typedef logic [PORT_IDX_W-1:0] port_idx_t;
  typedef logic [WORD_SEL_W-1:0] word_sel_t;
  typedef logic [PENDING_PTR_W-1:0] pending_ptr_t;
  typedef logic [PENDING_CNT_W-1:0] pending_cnt_t;

  typedef enum logic [1:0] {
    Idle,
    Request,
    WaitResponse,
    PresentResponse
  } port_state_e;

  typedef struct packed {
    word_t data;
    logic  error;
  } fetch_rsp_t;

  typedef struct packed {
    line_t data;
    logic  error;
  } line_rsp_t;

endpackage

`default_nettype wire

//--- rtl/fetch_port_fsm.sv
// ############################
// One fetch port of the bypass path
// The core must hold valid and address until ready
// Ready is a single-cycle pulse per fetch
// ############################

`timescale 1ns/1ps
`default_nettype none

module fetch_port_fsm (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  inst_valid_i,
  input  fetch_pkg::addr_t      inst_addr_i,
  input  logic                  pending_full_i,
  input  logic                  grant_i,
  input  logic                  rsp_strobe_i,
  input  fetch_pkg::line_rsp_t  mem_rsp_i,
  output logic                  req_o,
  output logic                  inst_ready_o,
  output fetch_pkg::fetch_rsp_t inst_rsp_o
);

  fetch_pkg::port_state_e state_q;
  fetch_pkg::port_state_e state_d;
  fetch_pkg::word_sel_t   word_sel;
  fetch_pkg::fetch_rsp_t  rsp_q;

  // Next state and the request towards the arbiter
  always_comb begin
    state_d = state_q;
    req_o = 1'b0;
    unique case (state_q)
      fetch_pkg::Idle: begin
        if (inst_valid_i) begin
          state_d = fetch_pkg::Request;
        end
      end
      fetch_pkg::Request: begin
        // Hold back while no slot is left for the returning line
        if (!pending_full_i) begin
          req_o = 1'b1;
          if (grant_i) begin
            state_d = fetch_pkg::WaitResponse;
          end
        end
      end
      fetch_pkg::WaitResponse: begin
        if (rsp_strobe_i) begin
          state_d = fetch_pkg::PresentResponse;
        end
      end
      fetch_pkg::PresentResponse: begin
        state_d = fetch_pkg::Idle;
      end
      default: begin
        state_d = fetch_pkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= fetch_pkg::Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // The address is still held by the core, so it picks the word out of the line
  assign word_sel = inst_addr_i[fetch_pkg::LINE_ALIGN-1:fetch_pkg::FETCH_ALIGN];

  // The word stays here until the next line for this port arrives
  always_ff @(posedge clk_i) begin
    if (rsp_strobe_i) begin
      rsp_q.data  <= mem_rsp_i.data[word_sel*fetch_pkg::FETCH_DW +: fetch_pkg::FETCH_DW];
      rsp_q.error <= mem_rsp_i.error;
    end
  end

  assign inst_ready_o = (state_q == fetch_pkg::PresentResponse);
  assign inst_rsp_o = rsp_q;

  // The arbiter only grants a port that is asking for a line
  a_grant_in_request : assert property (
    @(posedge clk_i) disable iff (reset_i)
    grant_i |-> (state_q == fetch_pkg::Request)
  );

  // The tracker only routes a line to a port that is waiting for one
  a_strobe_in_wait : assert property (
    @(posedge clk_i) disable iff (reset_i)
    rsp_strobe_i |-> (state_q == fetch_pkg::WaitResponse)
  );

endmodule

`default_nettype wire

//--- rtl/line_request_arbiter.sv
// ############################
// Round-robin arbiter onto the line request channel
// A stalled request keeps its port and address
// Addresses leave line aligned
// ############################

`timescale 1ns/1ps
`default_nettype none

module line_request_arbiter (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  fetch_pkg::port_mask_t                        port_req_i,
  input  fetch_pkg::addr_t [fetch_pkg::NUM_PORTS-1:0]  port_addr_i,
  input  logic                                         mem_req_ready_i,
  output fetch_pkg::port_mask_t                        grant_o,
  output logic                                         mem_req_valid_o,
  output fetch_pkg::addr_t                             mem_req_addr_o
);

  fetch_pkg::port_idx_t last_q;
  fetch_pkg::port_idx_t hold_idx_q;
  logic                 hold_q;
  fetch_pkg::port_idx_t rr_idx;
  fetch_pkg::port_idx_t sel_idx;
  fetch_pkg::addr_t     sel_addr;
  logic                 transfer;

  // Search downwards so the nearest port after the last winner is assigned last
  always_comb begin : rr_search
    int cand;
    rr_idx = last_q;
    for (int k = fetch_pkg::NUM_PORTS; k >= 1; k--) begin
      cand = (int'(last_q) + k) % fetch_pkg::NUM_PORTS;
      if (port_req_i[cand]) begin
        rr_idx = fetch_pkg::port_idx_t'(cand);
      end
    end
  end

  // Keep the stalled port on the channel until memory takes it
  assign sel_idx = (hold_q && port_req_i[hold_idx_q]) ? hold_idx_q : rr_idx;
  assign sel_addr = port_addr_i[sel_idx];

  assign mem_req_valid_o = |port_req_i;
  assign mem_req_addr_o = {sel_addr[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_ALIGN],
                           {fetch_pkg::LINE_ALIGN{1'b0}}};
  assign transfer = mem_req_valid_o && mem_req_ready_i;
  assign grant_o = transfer ? (fetch_pkg::port_mask_t'(1'b1) << sel_idx) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Port 0 wins first after reset
      last_q <= fetch_pkg::port_idx_t'(fetch_pkg::NUM_PORTS - 1);
      hold_q <= 1'b0;
    end else begin
      if (transfer) begin
        last_q <= sel_idx;
      end
      hold_q <= mem_req_valid_o && !mem_req_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_q <= sel_idx;
  end

  // A stalled request stays on the channel with the same line address
  a_req_held : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_addr_o))
  );

endmodule

`default_nettype wire

//--- rtl/refill_tracker.sv
// ############################
// In-order owner record for line refills in flight
// Memory must answer in request order
// At most PENDING_DEPTH refills are outstanding
// ############################

`timescale 1ns/1ps
`default_nettype none

module refill_tracker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  fetch_pkg::port_mask_t push_i,
  input  logic                  mem_rsp_valid_i,
  output logic                  full_o,
  output fetch_pkg::port_mask_t rsp_strobe_o
);

  fetch_pkg::port_mask_t  owner_mem [fetch_pkg::PENDING_DEPTH];
  fetch_pkg::pending_ptr_t wr_ptr_q;
  fetch_pkg::pending_ptr_t rd_ptr_q;
  fetch_pkg::pending_cnt_t count_q;
  logic                   push;
  logic                   pop;

  // Every grant starts a refill owned by the granted port
  assign push = |push_i;
  assign pop = mem_rsp_valid_i;

  assign full_o = (count_q == fetch_pkg::pending_cnt_t'(fetch_pkg::PENDING_DEPTH));

  // The oldest owner takes the line that comes back now
  assign rsp_strobe_o = mem_rsp_valid_i ? owner_mem[rd_ptr_q] : '0;

  always_ff @(posedge clk_i) begin
    if (push) begin
      owner_mem[wr_ptr_q] <= push_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Memory never answers more requests than were sent
  a_no_rsp_when_empty : assert property (
    @(posedge clk_i) disable iff (reset_i)
    mem_rsp_valid_i |-> (count_q != '0)
  );

  // Ports withdraw their requests while the record is full
  a_no_push_when_full : assert property (
    @(posedge clk_i) disable iff (reset_i)
    push |-> !full_o
  );

endmodule

`default_nettype wire

//--- rtl/bypass_fetch_top.sv
// ############################
// Uncacheable fetch path for NUM_PORTS cores
// Line responses must return in request order
// The response channel has no back-pressure
// ############################

`timescale 1ns/1ps
`default_nettype none

module bypass_fetch_top (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  fetch_pkg::port_mask_t                            inst_valid_i,
  input  fetch_pkg::addr_t [fetch_pkg::NUM_PORTS-1:0]      inst_addr_i,
  output fetch_pkg::port_mask_t                            inst_ready_o,
  output fetch_pkg::fetch_rsp_t [fetch_pkg::NUM_PORTS-1:0] inst_rsp_o,
  output logic                                             mem_req_valid_o,
  output fetch_pkg::addr_t                                 mem_req_addr_o,
  input  logic                                             mem_req_ready_i,
  input  logic                                             mem_rsp_valid_i,
  input  fetch_pkg::line_rsp_t                             mem_rsp_i
);

  fetch_pkg::port_mask_t port_req;
  fetch_pkg::port_mask_t grant;
  fetch_pkg::port_mask_t rsp_strobe;
  logic                  pending_full;

  // One request machine per core, all listening to the same line bus
  for (genvar i = 0; i < fetch_pkg::NUM_PORTS; i++) begin : gen_port
    fetch_port_fsm i_port_fsm (
      .clk_i          ( clk_i           ),
      .reset_i        ( reset_i         ),
      .inst_valid_i   ( inst_valid_i[i] ),
      .inst_addr_i    ( inst_addr_i[i]  ),
      .pending_full_i ( pending_full    ),
      .grant_i        ( grant[i]        ),
      .rsp_strobe_i   ( rsp_strobe[i]   ),
      .mem_rsp_i      ( mem_rsp_i       ),
      .req_o          ( port_req[i]     ),
      .inst_ready_o   ( inst_ready_o[i] ),
      .inst_rsp_o     ( inst_rsp_o[i]   )
    );
  end

  line_request_arbiter i_arbiter (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .port_req_i      ( port_req        ),
    .port_addr_i     ( inst_addr_i     ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .grant_o         ( grant           ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_addr_o  ( mem_req_addr_o  )
  );

  // The grant doubles as the owner entry for the refill
  refill_tracker i_tracker (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .push_i          ( grant           ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .full_o          ( pending_full    ),
    .rsp_strobe_o    ( rsp_strobe      )
  );

endmodule

`default_nettype wire

//--- sim/tb_line_memory.sv
// ############################
// Line memory model for the fetch testbench
// Responses return in request order after 1 to 6 cycles
// Lines with address bit 12 set answer with an error
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_line_memory (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 req_valid_i,
  input  fetch_pkg::addr_t     req_addr_i,
  output logic                 req_ready_o,
  output logic                 rsp_valid_o,
  output fetch_pkg::line_rsp_t rsp_o
);

  localparam int ERROR_BIT = 12;
  localparam int WORDS_PER_LINE = fetch_pkg::LINE_W / fetch_pkg::FETCH_DW;

  fetch_pkg::addr_t     pend_addr [$];
  longint               pend_due [$];
  longint               cycle_q = 0;
  logic                 ready_q = 1'b0;
  logic                 rsp_valid_q = 1'b0;
  fetch_pkg::line_rsp_t rsp_q = '0;

  // Every word is a scrambled copy of its own byte address
  function automatic fetch_pkg::word_t word_at(input fetch_pkg::addr_t addr);
    fetch_pkg::word_t x;
    x = addr ^ 32'h9e3779b9;
    x = x * 32'h85ebca6b;
    x = x ^ (x >> 13) ^ {addr[15:0], addr[31:16]};
    return x;
  endfunction

  function automatic fetch_pkg::line_rsp_t read_line(input fetch_pkg::addr_t line_addr);
    fetch_pkg::line_rsp_t line;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      line.data[w*fetch_pkg::FETCH_DW +: fetch_pkg::FETCH_DW] =
        word_at(line_addr + fetch_pkg::addr_t'(w * (fetch_pkg::FETCH_DW / 8)));
    end
    line.error = line_addr[ERROR_BIT];
    return line;
  endfunction

  always @(posedge clk_i) begin : model
    longint due;
    if (reset_i) begin
      pend_addr.delete();
      pend_due.delete();
      ready_q <= 1'b0;
      rsp_valid_q <= 1'b0;
      cycle_q <= 0;
    end else begin
      cycle_q <= cycle_q + 1;
      if (pend_due.size() > 0 && pend_due[0] <= cycle_q) begin
        rsp_valid_q <= 1'b1;
        rsp_q <= read_line(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        rsp_valid_q <= 1'b0;
      end
      if (req_valid_i && ready_q) begin
        due = cycle_q + longint'($urandom_range(1, 6));
        // At most one response per cycle, and never ahead of an older one
        if (pend_due.size() > 0 && due <= pend_due[$]) begin
          due = pend_due[$] + 1;
        end
        pend_addr.push_back(req_addr_i);
        pend_due.push_back(due);
      end
      ready_q <= ($urandom_range(0, 3) != 0);
    end
  end

  assign req_ready_o = ready_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

//--- sim/tb_bypass_fetch.sv
// ############################
// Testbench for the bypass fetch path
// Port p fetches only addresses with bit 13 equal to p
// so each memory request names its owner
// ############################

`timescale 1ns/1ps
`default_nettype none

module tb_bypass_fetch;

  localparam int CLK_PERIOD_NS = 40;
  localparam int RESET_CYCLES = 10;
  localparam int SEED = 20;
  localparam int NUM_FETCHES = 400;
  localparam int FETCHES_PER_PORT = NUM_FETCHES / fetch_pkg::NUM_PORTS;
  localparam int CYCLES_PER_FETCH = 20;
  localparam int ERROR_BIT = 12;
  localparam int PORT_BIT = 13;

  logic                                             clk;
  logic                                             reset;
  fetch_pkg::port_mask_t                            inst_valid;
  fetch_pkg::addr_t [fetch_pkg::NUM_PORTS-1:0]      inst_addr;
  fetch_pkg::port_mask_t                            inst_ready;
  fetch_pkg::fetch_rsp_t [fetch_pkg::NUM_PORTS-1:0] inst_rsp;
  logic                                             mem_req_valid;
  fetch_pkg::addr_t                                 mem_req_addr;
  logic                                             mem_req_ready;
  logic                                             mem_rsp_valid;
  fetch_pkg::line_rsp_t                             mem_rsp;

  int               errors = 0;
  logic             active [fetch_pkg::NUM_PORTS];
  logic             sent [fetch_pkg::NUM_PORTS];
  fetch_pkg::addr_t exp_addr [fetch_pkg::NUM_PORTS];
  int               completed [fetch_pkg::NUM_PORTS];
  int               last_winner;
  logic             rival_waiting;

  bypass_fetch_top uut (
    .clk_i           ( clk           ),
    .reset_i         ( reset         ),
    .inst_valid_i    ( inst_valid    ),
    .inst_addr_i     ( inst_addr     ),
    .inst_ready_o    ( inst_ready    ),
    .inst_rsp_o      ( inst_rsp      ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_addr_o  ( mem_req_addr  ),
    .mem_req_ready_i ( mem_req_ready ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       )
  );

  tb_line_memory i_memory (
    .clk_i       ( clk           ),
    .reset_i     ( reset         ),
    .req_valid_i ( mem_req_valid ),
    .req_addr_i  ( mem_req_addr  ),
    .req_ready_o ( mem_req_ready ),
    .rsp_valid_o ( mem_rsp_valid ),
    .rsp_o       ( mem_rsp       )
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // Expected word under the memory rule that scrambles the word address
  function automatic fetch_pkg::word_t expected_word(input fetch_pkg::addr_t addr);
    fetch_pkg::addr_t a;
    fetch_pkg::word_t x;
    a = addr & ~fetch_pkg::addr_t'((1 << fetch_pkg::FETCH_ALIGN) - 1);
    x = a ^ 32'h9e3779b9;
    x = x * 32'h85ebca6b;
    x = x ^ (x >> 13) ^ {a[15:0], a[31:16]};
    return x;
  endfunction

  function automatic fetch_pkg::addr_t line_of(input fetch_pkg::addr_t addr);
    return addr & ~fetch_pkg::addr_t'((1 << fetch_pkg::LINE_ALIGN) - 1);
  endfunction

  function automatic fetch_pkg::addr_t random_fetch_addr(input int p);
    fetch_pkg::addr_t a;
    a = $urandom;
    a[PORT_BIT] = p[0];
    a[fetch_pkg::FETCH_ALIGN-1:0] = '0;
    return a;
  endfunction

  // Issues fetches on one port, sometimes back to back with valid held high
  task automatic drive_port(input int p, input int count);
    int gap;
    for (int n = 0; n < count; n++) begin
      gap = $urandom_range(0, 3);
      if (gap != 0) begin
        inst_valid[p] <= 1'b0;
        repeat (gap) @(posedge clk);
      end
      inst_valid[p] <= 1'b1;
      inst_addr[p] <= random_fetch_addr(p);
      @(posedge clk);
      while (!inst_ready[p]) @(posedge clk);
    end
    inst_valid[p] <= 1'b0;
  endtask

  // Tracks every fetch from its first valid cycle to its ready pulse
  always @(posedge clk) begin : monitor
    int w;
    if (reset) begin
      for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
        active[p] = 1'b0;
        sent[p] = 1'b0;
        completed[p] = 0;
      end
      last_winner = -1;
      rival_waiting = 1'b0;
    end else begin
      if (mem_req_valid && mem_req_ready) begin
        w = int'(mem_req_addr[PORT_BIT]);
        check_value(64'(mem_req_addr[fetch_pkg::LINE_ALIGN-1:0]), '0, "request alignment");
        check_value(64'({active[w], sent[w]}), 64'(2'b10), "request without waiting fetch");
        check_value(64'(mem_req_addr), 64'(line_of(exp_addr[w])), "request line address");
        check_value(64'(last_winner == w && rival_waiting), '0, "round-robin order");
        // The other port lost this round if it was already asking
        rival_waiting = active[w ^ 1] && !sent[w ^ 1];
        last_winner = w;
        sent[w] = 1'b1;
      end
      for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
        if (inst_ready[p]) begin
          check_value(64'(active[p] && sent[p]), 64'd1, "ready without issued fetch");
          check_value(64'(inst_rsp[p].data), 64'(expected_word(exp_addr[p])), "fetch data");
          check_value(64'(inst_rsp[p].error), 64'(exp_addr[p][ERROR_BIT]), "fetch error bit");
          active[p] = 1'b0;
          completed[p]++;
        end else if (inst_valid[p] && !active[p]) begin
          active[p] = 1'b1;
          sent[p] = 1'b0;
          exp_addr[p] = inst_addr[p];
        end
      end
    end
  end

  initial begin : watchdog
    #(NUM_FETCHES * CYCLES_PER_FETCH * CLK_PERIOD_NS);
    $display("Timeout: the fetches did not finish within the allowed time");
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    void'($urandom(SEED));
    reset <= 1'b1;
    inst_valid <= '0;
    inst_addr <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // Nothing may move before the first fetch
    repeat (5) begin
      @(posedge clk);
      check_value(64'(inst_ready), '0, "ready before any fetch");
      check_value(64'(mem_req_valid), '0, "memory request before any fetch");
    end
    fork
      drive_port(0, FETCHES_PER_PORT);
      drive_port(1, FETCHES_PER_PORT);
    join
    repeat (10) @(posedge clk);
    for (int p = 0; p < fetch_pkg::NUM_PORTS; p++) begin
      check_value(64'(completed[p]), 64'(FETCHES_PER_PORT), "completed fetches per port");
    end
    check_value(64'(mem_req_valid), '0, "memory request after the last fetch");
    $display("Run finished with %0d errors, %0d and %0d fetches completed",
             errors, completed[0], completed[1]);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rtl/fetch_pkg.sv
rtl/fetch_port_fsm.sv
rtl/line_request_arbiter.sv
rtl/refill_tracker.sv
rtl/bypass_fetch_top.sv
sim/tb_line_memory.sv
sim/tb_bypass_fetch.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the fetch path testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f project.f --top-module tb_bypass_fetch \
  -o tb_bypass_fetch_sim > build.log 2>&1 \
  && ./obj_dir/tb_bypass_fetch_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or run did not complete"; exit 1; }
cat sim.log
# The log decides the result
grep -q "Simulation failed" sim.log && exit 1 || exit 0
